//--- menu_pkg.sv
package menu_pkg;

    ////////////////////////////////////////////////////////////////////
    // Menu layout
    ////////////////////////////////////////////////////////////////////

    // Items on the main page
    localparam int MAIN_ITEMS = 4;

    // Choices on the exit page, yes then no
    localparam int EXIT_ITEMS = 2;

    ////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        PAGE_MAIN    = 3'd0,
        PAGE_START   = 3'd1,
        PAGE_CONTROL = 3'd2,
        PAGE_ABOUT   = 3'd3,
        PAGE_EXIT    = 3'd4
    } menu_page_t;

    // Item on main, or 0 = yes / 1 = no on exit
    typedef logic [1:0] menu_cursor_t;

    // Raw key levels or one-cycle press strobes
    typedef struct packed {
        logic up;
        logic down;
        logic enter;
    } menu_keys_t;

    typedef struct packed {
        menu_page_t   page;
        menu_cursor_t cursor;
    } menu_status_t;

endpackage

//--- video_pkg.sv
package video_pkg;

    ////////////////////////////////////////////////////////////////////
    // 640x480 timing, one pixel per clock
    ////////////////////////////////////////////////////////////////////

    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

    // Menu panel geometry
    localparam int MENU_X0 = 160;
    localparam int MENU_X1 = 480;
    localparam int MENU_Y0 = 120;
    localparam int ITEM_H  = 60;

    ////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Sync bits active low
    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        hsync;
        logic        vsync;
    } vga_pos_t;

    typedef struct packed {
        vga_pos_t pos;
        logic     blank;
        rgb_t     rgb;
    } vga_bus_t;

    // Palette
    localparam rgb_t COLOR_BG           = '{r: 4'h1, g: 4'h2, b: 4'h4};
    localparam rgb_t COLOR_ITEM         = '{r: 4'h8, g: 4'h8, b: 4'h8};
    localparam rgb_t COLOR_HILITE       = '{r: 4'hF, g: 4'hC, b: 4'h0};
    localparam rgb_t COLOR_BLACK        = '{r: 4'h0, g: 4'h0, b: 4'h0};
    localparam rgb_t COLOR_PAGE_START   = '{r: 4'h0, g: 4'hA, b: 4'h2};
    localparam rgb_t COLOR_PAGE_CONTROL = '{r: 4'h2, g: 4'h6, b: 4'hE};
    localparam rgb_t COLOR_PAGE_ABOUT   = '{r: 4'hA, g: 4'h3, b: 4'hC};

endpackage

//--- signal_delay.sv
`timescale 1ns/1ns

module signal_delay #(
    parameter type T      = logic,
    parameter int  STAGES = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     d,
    output T     q
);

    T stage [STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stage[i] <= T'(0);
            end
        end else begin
            stage[0] <= d;
            // Shift toward the last stage
            for (int i = 1; i < STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[STAGES-1];

endmodule

//--- key_press.sv
`timescale 1ns/1ns

module key_press (
    input  logic                clk,
    input  logic                rst,
    input  menu_pkg::menu_keys_t keys,
    output menu_pkg::menu_keys_t press
);

    menu_pkg::menu_keys_t keys_sync;
    menu_pkg::menu_keys_t keys_prev;

    ////////////////////////////////////////////////////////////////////
    // Two-stage synchronizer for the asynchronous key levels
    ////////////////////////////////////////////////////////////////////

    signal_delay #(
        .T      (menu_pkg::menu_keys_t),
        .STAGES (2)
    ) u_sync (
        .clk (clk),
        .rst (rst),
        .d   (keys),
        .q   (keys_sync)
    );

    ////////////////////////////////////////////////////////////////////
    // Rising edge detect
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            keys_prev <= '0;
            press     <= '0;
        end else begin
            keys_prev <= keys_sync;
            // One strobe per low-to-high transition, held keys stay quiet
            press     <= menu_pkg::menu_keys_t'(keys_sync & ~keys_prev);
        end
    end

endmodule

//--- menu_fsm.sv
`timescale 1ns/1ns

module menu_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  menu_pkg::menu_keys_t   press,
    output menu_pkg::menu_status_t status,
    output logic                  quit
);

    localparam menu_pkg::menu_cursor_t CURSOR_LAST =
        menu_pkg::menu_cursor_t'(menu_pkg::MAIN_ITEMS - 1);

    menu_pkg::menu_status_t status_nxt;
    logic                   quit_nxt;

    ////////////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            status.page   <= menu_pkg::PAGE_MAIN;
            status.cursor <= '0;
            quit          <= 1'b0;
        end else begin
            status <= status_nxt;
            quit   <= quit_nxt;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        status_nxt = status;
        quit_nxt   = 1'b0;

        case (status.page)
            menu_pkg::PAGE_MAIN: begin
                if (press.up) begin
                    if (status.cursor != '0) begin
                        status_nxt.cursor = status.cursor - 2'd1;
                    end
                end else if (press.down) begin
                    if (status.cursor != CURSOR_LAST) begin
                        status_nxt.cursor = status.cursor + 2'd1;
                    end
                end else if (press.enter) begin
                    // Item index selects the page
                    case (status.cursor)
                        2'd0:    status_nxt.page = menu_pkg::PAGE_START;
                        2'd1:    status_nxt.page = menu_pkg::PAGE_CONTROL;
                        2'd2:    status_nxt.page = menu_pkg::PAGE_ABOUT;
                        default: status_nxt.page = menu_pkg::PAGE_EXIT;
                    endcase
                    status_nxt.cursor = '0;
                end
            end

            // Information pages only react to enter
            menu_pkg::PAGE_START,
            menu_pkg::PAGE_CONTROL,
            menu_pkg::PAGE_ABOUT: begin
                if (press.enter) begin
                    status_nxt.page = menu_pkg::PAGE_MAIN;
                end
            end

            menu_pkg::PAGE_EXIT: begin
                if (press.up) begin
                    status_nxt.cursor = 2'd0;
                end else if (press.down) begin
                    status_nxt.cursor = 2'd1;
                end else if (press.enter) begin
                    if (status.cursor == 2'd0) begin
                        // Yes, stay here and signal the game to quit
                        quit_nxt = 1'b1;
                    end else begin
                        status_nxt.page   = menu_pkg::PAGE_MAIN;
                        status_nxt.cursor = '0;
                    end
                end
            end

            default: begin
                status_nxt.page   = menu_pkg::PAGE_MAIN;
                status_nxt.cursor = '0;
            end
        endcase
    end

endmodule

//--- vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
    input  logic                clk,
    input  logic                rst,
    output video_pkg::vga_pos_t pos,
    output logic                blank
);

    localparam int H_SYNC_START = video_pkg::H_ACTIVE + video_pkg::H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + video_pkg::H_SYNC;
    localparam int V_SYNC_START = video_pkg::V_ACTIVE + video_pkg::V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + video_pkg::V_SYNC;

    logic [10:0] hcount;
    logic [9:0]  vcount;

    ////////////////////////////////////////////////////////////////////
    // Pixel and line counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == 11'(video_pkg::H_TOTAL - 1)) begin
            hcount <= '0;
            if (vcount == 10'(video_pkg::V_TOTAL - 1)) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 10'd1;
            end
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Sync and blanking decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        pos.hcount = hcount;
        pos.vcount = vcount;
        // Sync pulses are active low
        pos.hsync  = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_END));
        pos.vsync  = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_END));
        blank      = (hcount >= video_pkg::H_ACTIVE) || (vcount >= video_pkg::V_ACTIVE);
    end

endmodule

//--- menu_render.sv
`timescale 1ns/1ns

module menu_render (
    input  logic                   clk,
    input  logic                   rst,
    input  video_pkg::vga_pos_t    pos,
    input  logic                   blank,
    input  menu_pkg::menu_status_t status,
    output video_pkg::rgb_t        color
);

    logic                             in_x;
    logic [menu_pkg::MAIN_ITEMS-1:0] band_hit;
    int                               band_count;
    video_pkg::rgb_t                  color_nxt;

    ////////////////////////////////////////////////////////////////////
    // Band decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        in_x = (pos.hcount >= video_pkg::MENU_X0) && (pos.hcount < video_pkg::MENU_X1);
        for (int i = 0; i < menu_pkg::MAIN_ITEMS; i++) begin
            band_hit[i] = in_x &&
                (pos.vcount >= video_pkg::MENU_Y0 + i * video_pkg::ITEM_H) &&
                (pos.vcount < video_pkg::MENU_Y0 + (i + 1) * video_pkg::ITEM_H);
        end
    end

    // Exit page shows only yes and no
    assign band_count = (status.page == menu_pkg::PAGE_EXIT) ?
                        menu_pkg::EXIT_ITEMS : menu_pkg::MAIN_ITEMS;

    ////////////////////////////////////////////////////////////////////
    // Color select
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        color_nxt = video_pkg::COLOR_BG;
        case (status.page)
            menu_pkg::PAGE_MAIN,
            menu_pkg::PAGE_EXIT: begin
                for (int i = 0; i < menu_pkg::MAIN_ITEMS; i++) begin
                    if (band_hit[i] && (i < band_count)) begin
                        color_nxt = (i == int'(status.cursor)) ?
                                    video_pkg::COLOR_HILITE : video_pkg::COLOR_ITEM;
                    end
                end
            end
            menu_pkg::PAGE_START: begin
                if (|band_hit) color_nxt = video_pkg::COLOR_PAGE_START;
            end
            menu_pkg::PAGE_CONTROL: begin
                if (|band_hit) color_nxt = video_pkg::COLOR_PAGE_CONTROL;
            end
            menu_pkg::PAGE_ABOUT: begin
                if (|band_hit) color_nxt = video_pkg::COLOR_PAGE_ABOUT;
            end
            default: color_nxt = video_pkg::COLOR_BG;
        endcase
        if (blank) color_nxt = video_pkg::COLOR_BLACK;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            color <= video_pkg::COLOR_BLACK;
        end else begin
            color <= color_nxt;
        end
    end

endmodule

//--- menu_top.sv
`timescale 1ns/1ns

module menu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  menu_pkg::menu_keys_t   keys,
    output menu_pkg::menu_status_t status,
    output logic                   quit,
    output video_pkg::vga_bus_t    vga
);

    menu_pkg::menu_keys_t press;
    video_pkg::vga_pos_t  pos;
    logic                 blank;
    video_pkg::rgb_t      color;
    video_pkg::vga_bus_t  timing_bus;
    video_pkg::vga_bus_t  timing_bus_d;

    ////////////////////////////////////////////////////////////////////
    // Key input and menu control
    ////////////////////////////////////////////////////////////////////

    key_press u_key_press (
        .clk   (clk),
        .rst   (rst),
        .keys  (keys),
        .press (press)
    );

    menu_fsm u_menu_fsm (
        .clk    (clk),
        .rst    (rst),
        .press  (press),
        .status (status),
        .quit   (quit)
    );

    ////////////////////////////////////////////////////////////////////
    // Video path
    ////////////////////////////////////////////////////////////////////

    vga_timing u_vga_timing (
        .clk   (clk),
        .rst   (rst),
        .pos   (pos),
        .blank (blank)
    );

    menu_render u_menu_render (
        .clk    (clk),
        .rst    (rst),
        .pos    (pos),
        .blank  (blank),
        .status (status),
        .color  (color)
    );

    // Timing is delayed one cycle to match the registered color
    assign timing_bus = '{pos: pos, blank: blank, rgb: video_pkg::COLOR_BLACK};

    signal_delay #(
        .T      (video_pkg::vga_bus_t),
        .STAGES (1)
    ) u_video_delay (
        .clk (clk),
        .rst (rst),
        .d   (timing_bus),
        .q   (timing_bus_d)
    );

    assign vga = '{pos: timing_bus_d.pos, blank: timing_bus_d.blank, rgb: color};

endmodule

//--- menu_chk.sv
`timescale 1ns/1ns

module menu_chk (
    input logic                   clk,
    input logic                   rst,
    input menu_pkg::menu_keys_t   press,
    input menu_pkg::menu_status_t status,
    input logic                   quit
);

    // Failed assertions, read by the testbench summary
    int assert_errors = 0;

    //////////////////////////////////////////////////////////////////////
    // Menu state machine properties
    //////////////////////////////////////////////////////////////////////

    // Quit only from the confirmation page
    a_quit_on_exit: assert property (@(posedge clk) disable iff (rst)
        quit |-> (status.page == menu_pkg::PAGE_EXIT))
        else begin
            $error("quit raised outside the exit page");
            assert_errors++;
        end

    // Yes or no only
    a_exit_cursor: assert property (@(posedge clk) disable iff (rst)
        (status.page == menu_pkg::PAGE_EXIT) |-> (status.cursor <= 2'd1))
        else begin
            $error("cursor beyond the no choice on the exit page");
            assert_errors++;
        end

    a_page_legal: assert property (@(posedge clk) disable iff (rst)
        status.page inside {menu_pkg::PAGE_MAIN, menu_pkg::PAGE_START,
                            menu_pkg::PAGE_CONTROL, menu_pkg::PAGE_ABOUT,
                            menu_pkg::PAGE_EXIT})
        else begin
            $error("page holds an undefined value");
            assert_errors++;
        end

    // Any status change follows a strobe by one cycle
    a_change_after_press: assert property (@(posedge clk) disable iff (rst)
        (status != $past(status)) |-> $past(press != '0))
        else begin
            $error("status changed without a key strobe");
            assert_errors++;
        end

endmodule

//--- tb_menu.sv
`timescale 1ns/1ns

module tb_menu;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int KEY_UP      = 0;
    localparam int KEY_DOWN    = 1;
    localparam int KEY_ENTER   = 2;
    // Three frames plus room for the key tests
    localparam longint WATCHDOG_CYCLES =
        3 * video_pkg::H_TOTAL * video_pkg::V_TOTAL + 2000;

    logic                   clk;
    logic                   rst;
    menu_pkg::menu_keys_t   keys;
    menu_pkg::menu_status_t status;
    logic                   quit;
    video_pkg::vga_bus_t    vga;

    menu_pkg::menu_status_t exp_status;
    int                     exp_quits;
    int                     quit_seen;
    int                     status_errors;
    int                     quit_errors;
    int                     color_errors;
    int                     timing_errors;
    int                     seed;

    menu_top u_menu_top (
        .clk    (clk),
        .rst    (rst),
        .keys   (keys),
        .status (status),
        .quit   (quit),
        .vga    (vga)
    );

    bind menu_fsm menu_chk u_menu_chk (
        .clk    (clk),
        .rst    (rst),
        .press  (press),
        .status (status),
        .quit   (quit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One count per cycle with quit high
    always @(posedge clk) begin
        if (!rst && quit) begin
            quit_seen++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_status(input menu_pkg::menu_status_t got,
                                input menu_pkg::menu_status_t exp, input string what);
        if (got !== exp) begin
            status_errors++;
            $display("ERR %0t: %s, got page %0d cursor %0d, expected page %0d cursor %0d",
                     $time, what, got.page, got.cursor, exp.page, exp.cursor);
        end
    endtask

    task automatic check_quit(input int got, input int exp, input string what);
        if (got != exp) begin
            quit_errors++;
            $display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_color(input video_pkg::rgb_t got, input video_pkg::rgb_t exp,
                               input string what);
        if (got !== exp) begin
            color_errors++;
            $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Sync and blanking bits only, the position is the wait condition
    task automatic check_timing(input video_pkg::vga_pos_t got, input logic got_blank,
                                input video_pkg::vga_pos_t exp, input logic exp_blank,
                                input string what);
        if (got.hsync !== exp.hsync || got.vsync !== exp.vsync ||
            got_blank !== exp_blank) begin
            timing_errors++;
            $display("ERR %0t: %s, got hsync %b vsync %b blank %b, %s %b %b %b",
                     $time, what, got.hsync, got.vsync, got_blank,
                     "expected hsync vsync blank", exp.hsync, exp.vsync, exp_blank);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model and drivers
    //////////////////////////////////////////////////////////////////////

    task automatic model_apply(input int key);
        case (exp_status.page)
            menu_pkg::PAGE_MAIN: begin
                if (key == KEY_UP && exp_status.cursor != 2'd0) begin
                    exp_status.cursor = exp_status.cursor - 2'd1;
                end else if (key == KEY_DOWN && exp_status.cursor != 2'd3) begin
                    exp_status.cursor = exp_status.cursor + 2'd1;
                end else if (key == KEY_ENTER) begin
                    case (exp_status.cursor)
                        2'd0:    exp_status.page = menu_pkg::PAGE_START;
                        2'd1:    exp_status.page = menu_pkg::PAGE_CONTROL;
                        2'd2:    exp_status.page = menu_pkg::PAGE_ABOUT;
                        default: exp_status.page = menu_pkg::PAGE_EXIT;
                    endcase
                    exp_status.cursor = 2'd0;
                end
            end
            menu_pkg::PAGE_EXIT: begin
                if (key == KEY_UP) begin
                    exp_status.cursor = 2'd0;
                end else if (key == KEY_DOWN) begin
                    exp_status.cursor = 2'd1;
                end else if (exp_status.cursor == 2'd0) begin
                    exp_quits++;
                end else begin
                    exp_status = '{page: menu_pkg::PAGE_MAIN, cursor: 2'd0};
                end
            end
            default: begin
                // Information pages
                if (key == KEY_ENTER) begin
                    exp_status.page = menu_pkg::PAGE_MAIN;
                end
            end
        endcase
    endtask

    // Hold one key, release, let the result settle, then compare
    task automatic press_key(input int key, input int hold);
        menu_pkg::menu_keys_t drive;
        drive = '0;
        case (key)
            KEY_UP:   drive.up = 1'b1;
            KEY_DOWN: drive.down = 1'b1;
            default:  drive.enter = 1'b1;
        endcase
        @(posedge clk);
        #(DRIVE_DELAY);
        keys = drive;
        repeat (hold) @(posedge clk);
        #(DRIVE_DELAY);
        keys = '0;
        repeat (6) @(posedge clk);
        #(DRIVE_DELAY);
        model_apply(key);
        check_status(status, exp_status, "status after key press");
        check_quit(quit_seen, exp_quits, "quit pulse count");
    endtask

    task automatic color_at(input int h, input int v, input video_pkg::rgb_t exp,
                            input string what);
        video_pkg::vga_pos_t exp_pos;
        logic                exp_blank;
        exp_pos.hcount = 11'(h);
        exp_pos.vcount = 10'(v);
        // Active low pulses after the front porch
        exp_pos.hsync  = !((h >= video_pkg::H_ACTIVE + video_pkg::H_FP) &&
                           (h < video_pkg::H_ACTIVE + video_pkg::H_FP + video_pkg::H_SYNC));
        exp_pos.vsync  = !((v >= video_pkg::V_ACTIVE + video_pkg::V_FP) &&
                           (v < video_pkg::V_ACTIVE + video_pkg::V_FP + video_pkg::V_SYNC));
        exp_blank      = (h >= video_pkg::H_ACTIVE) || (v >= video_pkg::V_ACTIVE);
        @(negedge clk);
        while (vga.pos.hcount != h || vga.pos.vcount != v) begin
            @(negedge clk);
        end
        check_color(vga.rgb, exp, what);
        check_timing(vga.pos, vga.blank, exp_pos, exp_blank, what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        check_status(status, exp_status, "status after reset");
        check_quit(int'(quit), 0, "quit level after reset");
    endtask

    task automatic cursor_moves();
        press_key(KEY_UP, 3);
        // Long hold still gives one step
        press_key(KEY_DOWN, 20);
        repeat (3) press_key(KEY_DOWN, 3);
        repeat (3) press_key(KEY_UP, 3);
    endtask

    task automatic page_round_trip();
        for (int item = 0; item < 3; item++) begin
            repeat (item) press_key(KEY_DOWN, 3);
            press_key(KEY_ENTER, 3);
            press_key(KEY_ENTER, 3);
        end
    endtask

    task automatic exit_confirm();
        int quits_before;
        repeat (3) press_key(KEY_DOWN, 3);
        press_key(KEY_ENTER, 3);
        press_key(KEY_DOWN, 3);
        press_key(KEY_ENTER, 3);
        repeat (3) press_key(KEY_DOWN, 3);
        press_key(KEY_ENTER, 3);
        quits_before = quit_seen;
        press_key(KEY_UP, 3);
        press_key(KEY_ENTER, 3);
        check_quit(quit_seen - quits_before, 1, "quit pulses for yes");
        press_key(KEY_DOWN, 3);
        press_key(KEY_ENTER, 3);
    endtask

    // Points in raster order so one frame covers the main page
    task automatic render_colors();
        press_key(KEY_DOWN, 3);
        color_at(200, 130, video_pkg::COLOR_ITEM, "plain band 0");
        color_at(100, 200, video_pkg::COLOR_BG, "left of panel");
        color_at(300, 200, video_pkg::COLOR_HILITE, "highlighted band 1");
        color_at(320, 400, video_pkg::COLOR_BG, "below panel");
        color_at(700, 420, video_pkg::COLOR_BLACK, "blanking");
        color_at(10, 491, video_pkg::COLOR_BLACK, "vertical sync line");
        press_key(KEY_ENTER, 3);
        color_at(250, 300, video_pkg::COLOR_PAGE_CONTROL, "control page panel");
        press_key(KEY_ENTER, 3);
    endtask

    task automatic random_keys();
        int key;
        for (int n = 0; n < 200; n++) begin
            key = int'($unsigned($random(seed)) % 3);
            press_key(key, 3);
        end
    endtask

    initial begin
        rst           = 1'b1;
        keys          = '0;
        exp_status    = '{page: menu_pkg::PAGE_MAIN, cursor: 2'd0};
        exp_quits     = 0;
        quit_seen     = 0;
        status_errors = 0;
        quit_errors   = 0;
        color_errors  = 0;
        timing_errors = 0;
        seed          = 32184;
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        reset_state();
        cursor_moves();
        page_round_trip();
        exit_confirm();
        render_colors();
        random_keys();
        $display("Errors: status %0d, quit %0d, color %0d, timing %0d, assertion %0d",
                 status_errors, quit_errors, color_errors, timing_errors,
                 u_menu_top.u_menu_fsm.u_menu_chk.assert_errors);
        if (status_errors + quit_errors + color_errors + timing_errors +
            u_menu_top.u_menu_fsm.u_menu_chk.assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within the time limit");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- sources.f
menu_pkg.sv
video_pkg.sv
signal_delay.sv
key_press.sv
menu_fsm.sv
vga_timing.sv
menu_render.sv
menu_top.sv
menu_chk.sv
tb_menu.sv

//--- Bender.yml
package:
  name: menu_subsystem

sources:
  - menu_pkg.sv
  - video_pkg.sv
  - signal_delay.sv
  - key_press.sv
  - menu_fsm.sv
  - vga_timing.sv
  - menu_render.sv
  - menu_top.sv
  - target: simulation
    files:
      - menu_chk.sv
      - tb_menu.sv
